// File: hdl/trig_link_pkg.sv
`default_nettype none

package trig_link_pkg;

   // Widths --------------------
   localparam int LINK_W = 56;              // Cluster payload per link
   localparam int GEM_W  = 2 * LINK_W;      // Both links, even link low
   localparam int HOLD_W = LINK_W - 8;      // Bytes sent after word 0
   localparam int APB_AW = 8;
   localparam int APB_DW = 32;

   typedef logic [LINK_W-1:0] link_data_t;
   typedef logic [GEM_W-1:0]  gem_data_t;
   typedef logic [7:0]        k_char_t;

   // Frame separators, 8b/10b K codes
   localparam k_char_t K_BC0      = 8'h1C; // K.28.0
   localparam k_char_t K_RESYNC   = 8'h3C; // K.28.1
   localparam k_char_t K_OVERFLOW = 8'hFE; // K.30.7, more than 8 clusters
   localparam k_char_t K_SEQ0     = 8'hBC; // K.28.5
   localparam k_char_t K_SEQ1     = 8'hF7; // K.23.7
   localparam k_char_t K_SEQ2     = 8'hFB; // K.27.7
   localparam k_char_t K_SEQ3     = 8'hFD; // K.29.7

   // Link words --------------------
   localparam logic [15:0] IDLE_WORD = 16'hFFFC; // Sent while not ready
   localparam logic [1:0]  IDLE_ISK  = 2'b01;
   localparam logic [1:0]  ISK_SEP   = 2'b01;    // K char in low byte
   localparam logic [1:0]  ISK_DATA  = 2'b00;

   typedef struct packed {
      logic [7:0] data;                     // Low payload byte
      k_char_t    sep;                      // Separator, goes out first
   } sep_word_t;

   // Word 0 is separator plus byte, the others are plain 16-bit data
   typedef union packed {
      sep_word_t   sep_word;
      logic [15:0] raw;
   } tx_word_u;

   typedef struct packed {
      tx_word_u   word;
      logic [1:0] isk;                      // Per-byte K flags
   } tx_link_t;

   typedef struct packed {
      logic       bc0;
      logic       resync;
      logic       overflow;
      logic [1:0] bx_lsbs;                  // Bunch-counter LSBs
   } ttc_t;

   // APB --------------------
   typedef struct packed {
      logic              psel;
      logic              penable;
      logic              pwrite;
      logic [APB_AW-1:0] paddr;
      logic [APB_DW-1:0] pwdata;
   } apb_req_t;

   typedef struct packed {
      logic [APB_DW-1:0] prdata;
      logic              pready;
      logic              pslverr;
   } apb_rsp_t;

   typedef struct packed {
      logic force_not_ready;                // Bit 3
      logic ttc_chars_en;                   // Bit 2
      logic frame_ctrl_ttc;                 // Bit 1
      logic restart;                        // Bit 0, self clearing
   } ctrl_t;

   localparam logic [APB_AW-1:0] ADDR_CTRL   = 8'h00;
   localparam logic [APB_AW-1:0] ADDR_STATUS = 8'h04;

endpackage

`default_nettype wire

// File: hdl/apb_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_ctrl_regs (
   input  wire                            clock_40,
   input  wire                            rst_n_i,
   input  wire trig_link_pkg::apb_req_t   apb_i,
   input  wire                            ready_i,
   input  wire                            startup_done_i,
   output trig_link_pkg::apb_rsp_t        apb_o,
   output trig_link_pkg::ctrl_t           ctrl_o
);

   import trig_link_pkg::*;

   // TTC characters on and cycle from the bunch counter out of reset
   localparam ctrl_t CTRL_RST = '{
      force_not_ready: 1'b0,
      ttc_chars_en:    1'b1,
      frame_ctrl_ttc:  1'b1,
      restart:         1'b0
   };

   logic  access;          // Access phase of a transfer
   logic  sel_ctrl;
   logic  sel_status;
   logic  addr_ok;
   ctrl_t ctrl_q;
   ctrl_t ctrl_rd;         // Readback view, restart always 0

   // Decode --------------------
   assign access     = apb_i.psel && apb_i.penable;
   assign sel_ctrl   = (apb_i.paddr == ADDR_CTRL);
   assign sel_status = (apb_i.paddr == ADDR_STATUS);
   assign addr_ok    = sel_ctrl || sel_status;

   // Control register --------------------
   always_ff @(posedge clock_40) begin
      if (!rst_n_i) begin
         ctrl_q <= CTRL_RST;
      end else begin
         ctrl_q.restart <= 1'b0;                                   // Pulse lasts one cycle
         if (access && apb_i.pwrite && sel_ctrl) begin
            ctrl_q <= ctrl_t'(apb_i.pwdata[$bits(ctrl_t)-1:0]);
         end
      end
   end

   assign ctrl_o = ctrl_q;

   // Response --------------------
   always_comb begin
      ctrl_rd         = ctrl_q;
      ctrl_rd.restart = 1'b0;
      apb_o.prdata    = '0;
      apb_o.pready    = 1'b1;                                     // No wait states
      apb_o.pslverr   = access && !addr_ok;                       // Unmapped address
      if (apb_i.psel && !apb_i.pwrite) begin
         if (sel_ctrl) begin
            apb_o.prdata = APB_DW'(ctrl_rd);
         end else if (sel_status) begin
            apb_o.prdata = APB_DW'({startup_done_i, ready_i});   // Bit 1 done, bit 0 ready
         end
      end
   end

   // Bus protocol from the master side
   a_penable_needs_psel : assert property (
      @(posedge clock_40) disable iff (!rst_n_i)
      apb_i.penable |-> apb_i.psel
   ) else $error("apb_ctrl_regs: penable without psel");

   a_access_after_setup : assert property (
      @(posedge clock_40) disable iff (!rst_n_i)
      access |-> $past(apb_i.psel && !apb_i.penable)
   ) else $error("apb_ctrl_regs: access phase without setup phase");

endmodule

`default_nettype wire

// File: hdl/link_startup.sv
`timescale 1ns/1ps
`default_nettype none

module link_startup #(
   parameter int STARTUP_CYCLES = 1024,     // Wait before the ready timer may run
   parameter int READY_CYCLES   = 256       // Ready timer length
) (
   input  wire  clock_40,
   input  wire  rst_n_i,
   input  wire  restart_i,                  // One-cycle pulse from the control register
   input  wire  force_not_ready_i,
   output logic startup_done_o,
   output logic ready_o
);

   localparam int SU_W  = $clog2(STARTUP_CYCLES + 2);
   localparam int RDY_W = $clog2(READY_CYCLES + 2);

   // Startup saturates one past STARTUP_CYCLES
   localparam logic [SU_W-1:0]  SU_MAX  = SU_W'(STARTUP_CYCLES + 1);
   localparam logic [RDY_W-1:0] RDY_MAX = RDY_W'(READY_CYCLES);

   logic [SU_W-1:0]  startup_cnt;
   logic [RDY_W-1:0] ready_cnt;

   // Startup counter --------------------
   always_ff @(posedge clock_40) begin
      if (!rst_n_i || restart_i) begin
         startup_cnt <= '0;
      end else if (startup_cnt != SU_MAX) begin
         startup_cnt <= startup_cnt + SU_W'(1);
      end
   end

   assign startup_done_o = (startup_cnt == SU_MAX); // Passed STARTUP_CYCLES

   // Ready timer --------------------
   // Runs only after startup, restarts from 0 whenever ready is forced off
   always_ff @(posedge clock_40) begin
      if (!rst_n_i || restart_i || force_not_ready_i || !startup_done_o) begin
         ready_cnt <= '0;
      end else if (ready_cnt != RDY_MAX) begin
         ready_cnt <= ready_cnt + RDY_W'(1);
      end
   end

   assign ready_o = (ready_cnt == RDY_MAX);

   // A restart clears both counters in the same cycle, ready must never outlive startup
   a_ready_after_startup : assert property (
      @(posedge clock_40) disable iff (!rst_n_i)
      ready_o |-> startup_done_o
   ) else $error("link_startup: ready high before startup finished");

endmodule

`default_nettype wire

// File: hdl/sep_char_select.sv
`timescale 1ns/1ps
`default_nettype none

module sep_char_select (
   input  wire                          clock_40,
   input  wire                          rst_n_i,
   input  wire trig_link_pkg::ttc_t     ttc_i,
   input  wire                          ready_i,
   input  wire                          frame_start_i,    // Word 0 of link 0
   input  wire                          ttc_chars_en_i,
   input  wire                          frame_ctrl_ttc_i, // Cycle from bunch counter
   output trig_link_pkg::k_char_t       sep_o
);

   import trig_link_pkg::*;

   logic [1:0] seq_cnt;    // Local bunch-sequence counter, one step per frame
   logic [1:0] seq_idx;    // Selected cycle position

   // Local counter --------------------
   // Starts at 0 on the first frame after ready, so the cycle opens with BC
   always_ff @(posedge clock_40) begin
      if (!rst_n_i || !ready_i) begin
         seq_cnt <= 2'd0;
      end else if (frame_start_i) begin
         seq_cnt <= seq_cnt + 2'd1;
      end
   end

   assign seq_idx = frame_ctrl_ttc_i ? ttc_i.bx_lsbs : seq_cnt;

   // Separator choice --------------------
   // TTC characters win over the bunch-sequence cycle, BC0 first
   always_comb begin
      if (ttc_chars_en_i && ttc_i.bc0) begin
         sep_o = K_BC0;
      end else if (ttc_chars_en_i && ttc_i.resync) begin
         sep_o = K_RESYNC;
      end else if (ttc_chars_en_i && ttc_i.overflow) begin
         sep_o = K_OVERFLOW;                   // Cluster overflow on this chamber
      end else begin
         case (seq_idx)
            2'd0:    sep_o = K_SEQ0;            // K.28.5
            2'd1:    sep_o = K_SEQ1;            // K.23.7
            2'd2:    sep_o = K_SEQ2;            // K.27.7
            default: sep_o = K_SEQ3;            // K.29.7
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hdl/link_framer.sv
`timescale 1ns/1ps
`default_nettype none

module link_framer #(
   parameter int FRAME_LEN = 4               // Fifth word is zero padding
) (
   input  wire                              clock_40,
   input  wire                              rst_n_i,
   input  wire                              ready_i,
   input  wire trig_link_pkg::link_data_t   link_data_i,
   input  wire trig_link_pkg::k_char_t      sep_i,
   output trig_link_pkg::tx_link_t          tx_o,
   output logic                             frame_start_o
);

   import trig_link_pkg::*;

   localparam int CNT_W = $clog2(FRAME_LEN);

   logic [CNT_W-1:0]  frame_cnt;             // Word position in the frame
   logic [HOLD_W-1:0] hold_q;                // Data bits 55:8 of this frame
   tx_link_t          tx_d;                  // Next output word

   if (FRAME_LEN != 4 && FRAME_LEN != 5) begin : g_len_chk
      $error("link_framer: FRAME_LEN must be 4 or 5");
   end

   // Frame counter --------------------
   // Held at 0 while not ready, so word 0 comes first after ready rises
   always_ff @(posedge clock_40) begin
      if (!rst_n_i || !ready_i) begin
         frame_cnt <= '0;
      end else if (frame_cnt == CNT_W'(FRAME_LEN - 1)) begin
         frame_cnt <= '0;
      end else begin
         frame_cnt <= frame_cnt + CNT_W'(1);
      end
   end

   assign frame_start_o = ready_i && (frame_cnt == '0);

   // Inputs are sampled only here, the rest of the frame is sent from the hold register
   always_ff @(posedge clock_40) begin
      if (frame_start_o) begin
         hold_q <= link_data_i[LINK_W-1:8];
      end
   end

   // Word mux --------------------
   always_comb begin
      tx_d.word.raw = '0;                     // Word 4 padding
      tx_d.isk      = ISK_DATA;
      case (frame_cnt)
         CNT_W'(0): begin
            tx_d.word.sep_word.data = link_data_i[7:0]; // Live byte, not yet held
            tx_d.word.sep_word.sep  = sep_i;
            tx_d.isk                = ISK_SEP;
         end
         CNT_W'(1): tx_d.word.raw = hold_q[15:0];   // Data 23:8
         CNT_W'(2): tx_d.word.raw = hold_q[31:16];  // Data 39:24
         CNT_W'(3): tx_d.word.raw = hold_q[47:32];  // Data 55:40
         default:   tx_d.word.raw = '0;
      endcase
   end

   // One cycle from counter value to link word
   always_ff @(posedge clock_40) begin
      if (!rst_n_i || !ready_i) begin
         tx_o.word.raw <= IDLE_WORD;
         tx_o.isk      <= IDLE_ISK;
      end else begin
         tx_o <= tx_d;
      end
   end

   // Counter must never reach a word slot outside the frame
   a_frame_cnt_range : assert property (
      @(posedge clock_40) disable iff (!rst_n_i)
      int'(frame_cnt) < FRAME_LEN
   ) else $error("link_framer: frame counter out of range");

endmodule

`default_nettype wire

// File: hdl/trig_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module trig_link_top #(
   parameter int N_LINKS        = 2,
   parameter int FRAME_LEN      = 4,      // 4 or 5 words per frame
   parameter int STARTUP_CYCLES = 1024,
   parameter int READY_CYCLES   = 256
) (
   input  wire                                     clock_40,
   input  wire                                     rst_n_i,
   input  wire trig_link_pkg::gem_data_t           gem_data_i,
   input  wire trig_link_pkg::ttc_t                ttc_i,
   input  wire trig_link_pkg::apb_req_t            apb_i,
   output wire trig_link_pkg::apb_rsp_t            apb_o,
   output wire trig_link_pkg::tx_link_t [N_LINKS-1:0] tx_o,
   output wire                                     ready_o
);

   import trig_link_pkg::*;

   ctrl_t               ctrl;             // Control register contents
   logic                startup_done;
   logic                ready;
   logic [N_LINKS-1:0]  frame_start;      // Only link 0 steps the sequence
   k_char_t             sep;              // Shared by all framers

   assign ready_o = ready;

   // Control --------------------
   apb_ctrl_regs u_apb_ctrl_regs (
      .clock_40       (clock_40),
      .rst_n_i        (rst_n_i),
      .apb_i          (apb_i),
      .ready_i        (ready),
      .startup_done_i (startup_done),
      .apb_o          (apb_o),
      .ctrl_o         (ctrl)
   );

   link_startup #(
      .STARTUP_CYCLES (STARTUP_CYCLES),
      .READY_CYCLES   (READY_CYCLES)
   ) u_link_startup (
      .clock_40          (clock_40),
      .rst_n_i           (rst_n_i),
      .restart_i         (ctrl.restart),
      .force_not_ready_i (ctrl.force_not_ready),
      .startup_done_o    (startup_done),
      .ready_o           (ready)
   );

   // Framing --------------------
   sep_char_select u_sep_char_select (
      .clock_40         (clock_40),
      .rst_n_i          (rst_n_i),
      .ttc_i            (ttc_i),
      .ready_i          (ready),
      .frame_start_i    (frame_start[0]),
      .ttc_chars_en_i   (ctrl.ttc_chars_en),
      .frame_ctrl_ttc_i (ctrl.frame_ctrl_ttc),
      .sep_o            (sep)
   );

   // Even links take the low half of the cluster word, odd links the high half
   for (genvar i = 0; i < N_LINKS; i++) begin : g_link
      link_framer #(
         .FRAME_LEN (FRAME_LEN)
      ) u_link_framer (
         .clock_40      (clock_40),
         .rst_n_i       (rst_n_i),
         .ready_i       (ready),
         .link_data_i   (gem_data_i[(i % 2) * LINK_W +: LINK_W]),
         .sep_i         (sep),
         .tx_o          (tx_o[i]),
         .frame_start_o (frame_start[i])
      );
   end

endmodule

`default_nettype wire

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter int HALF_NS      = 50,       // 100 ns period
   parameter int RESET_CYCLES = 2
) (
   output logic clock_40,
   output logic rst_n_o
);

   initial begin
      clock_40 = 1'b0;
      forever #(HALF_NS) clock_40 = ~clock_40;
   end

   // Reset released on a falling edge, like every other input
   initial begin
      rst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge clock_40);
      @(negedge clock_40);
      rst_n_o = 1'b1;
   end

endmodule

`default_nettype wire

// File: sim/tb_trig_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_trig_link;

   import trig_link_pkg::*;

   localparam int    WAIT_LIMIT = 200;                          // Cycles per bounded wait
   localparam int    SETTLE     = 10;                           // ns from drive to sample
   localparam string PAT_FILE   = "sim/trig_link_patterns.txt";

   logic           clock_40;
   logic           rst_n;
   gem_data_t      gem_data;
   ttc_t           ttc;
   apb_req_t       apb_req;
   apb_rsp_t       apb_rsp;
   tx_link_t [1:0] tx;
   logic           ready;
   logic [3:0]     ctrl_bits;                                   // Last CTRL written, restart 0

   tb_clock_gen u_clock_gen (
      .clock_40 (clock_40),
      .rst_n_o  (rst_n)
   );

   trig_link_top #(
      .FRAME_LEN      (4),
      .STARTUP_CYCLES (20),
      .READY_CYCLES   (10)
   ) UUT (
      .clock_40   (clock_40),
      .rst_n_i    (rst_n),
      .gem_data_i (gem_data),
      .ttc_i      (ttc),
      .apb_i      (apb_req),
      .apb_o      (apb_rsp),
      .tx_o       (tx),
      .ready_o    (ready)
   );

   // Checking --------------------
   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
         $display("TEST FAILED");
         $fatal(1, "Stopped at first mismatch");
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("TEST FAILED");
      $fatal(1, "Run aborted");
   endtask

   // Word 0 is data byte over separator, then three data slices
   function automatic tx_link_t expected_word(input link_data_t d, input k_char_t sep,
                                              input int w);
      tx_link_t t;
      t.isk = 2'b00;
      case (w)
         0: begin
            t.word.raw = {d[7:0], sep};
            t.isk      = 2'b01;                                 // K char in low byte
         end
         1:       t.word.raw = d[23:8];
         2:       t.word.raw = d[39:24];
         default: t.word.raw = d[55:40];
      endcase
      return t;
   endfunction

   // Waits --------------------
   task automatic wait_reset();
      int n = 0;
      while (rst_n !== 1'b1) begin
         @(posedge clock_40);                                   // Reset moves on falling edges
         n++;
         if (n > WAIT_LIMIT) abort_run("Timed out waiting for reset release");
      end
      @(negedge clock_40);
   endtask

   task automatic wait_ready(input logic level);
      int n = 0;
      while (ready !== level) begin
         @(negedge clock_40);
         n++;
         if (n > WAIT_LIMIT) abort_run($sformatf("Timed out waiting for ready_o = %0b", level));
      end
   endtask

   task automatic wait_idle();
      int n = 0;
      while (ready !== 1'b0 || tx[0] !== {16'hFFFC, 2'b01} || tx[1] !== {16'hFFFC, 2'b01}) begin
         @(negedge clock_40);
         n++;
         if (n > WAIT_LIMIT) abort_run("Timed out waiting for both links to go idle");
      end
   endtask

   // Idle also has isk 01, but FC in the low byte is never a separator
   task automatic wait_frame_start();
      int n = 0;
      do begin
         @(negedge clock_40);
         n++;
         if (n > WAIT_LIMIT) abort_run("Timed out waiting for a frame start on link 0");
      end while (!(tx[0].isk == 2'b01 && tx[0].word.raw[7:0] != 8'hFC));
   endtask

   // APB --------------------
   // Called on a falling edge, returns on a falling edge
   task automatic apb_transfer(input logic write, input logic [7:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output logic slverr);
      apb_req.psel    = 1'b1;                                   // Setup phase
      apb_req.penable = 1'b0;
      apb_req.pwrite  = write;
      apb_req.paddr   = addr;
      apb_req.pwdata  = wdata;
      @(negedge clock_40);
      apb_req.penable = 1'b1;                                   // Access phase
      #(SETTLE);
      check_value("apb_o.pready", 64'(apb_rsp.pready), 64'(1)); // No wait states
      rdata  = apb_rsp.prdata;
      slverr = apb_rsp.pslverr;
      @(negedge clock_40);
      apb_req = '0;
   endtask

   task automatic reg_write(input logic [7:0] addr, input logic [31:0] data,
                            input logic exp_err);
      logic [31:0] rd;
      logic        err;
      apb_transfer(1'b1, addr, data, rd, err);
      check_value($sformatf("pslverr on write to 0x%0h", addr), 64'(err), 64'(exp_err));
   endtask

   task automatic reg_check(input logic [7:0] addr, input logic [31:0] exp,
                            input logic exp_err, input string name);
      logic [31:0] rd;
      logic        err;
      apb_transfer(1'b0, addr, 32'h0, rd, err);
      check_value({"pslverr on read of ", name}, 64'(err), 64'(exp_err));
      if (!exp_err) begin
         check_value({"prdata ", name}, 64'(rd), 64'(exp));
      end
   endtask

   // CTRL bits 3..0 are force_not_ready, ttc_chars_en, frame_ctrl_ttc, restart
   task automatic write_ctrl(input logic force_nr, input logic ttc_en, input logic fctrl,
                             input logic restart);
      ctrl_bits = {force_nr, ttc_en, fctrl, 1'b0};              // Restart reads back 0
      reg_write(ADDR_CTRL, 32'({force_nr, ttc_en, fctrl, restart}), 1'b0);
   endtask

   // Frames --------------------
   // Starts on the falling edge that shows word 0 of link 0
   task automatic check_frame(input gem_data_t gem, input k_char_t sep);
      tx_link_t exp;
      for (int w = 0; w < 4; w++) begin
         if (w > 0) begin
            @(negedge clock_40);
         end
         for (int l = 0; l < 2; l++) begin
            exp = expected_word(gem[l*56 +: 56], sep, w);       // Even link low half
            check_value($sformatf("tx_o[%0d] word %0d", l, w), 64'(tx[l].word.raw),
                        64'(exp.word.raw));
            check_value($sformatf("tx_o[%0d] isk %0d", l, w), 64'(tx[l].isk), 64'(exp.isk));
         end
      end
   endtask

   task automatic run_patterns();
      int         fd;
      int         n_fields;
      int         n_lines = 0;
      string      line;
      gem_data_t  p_gem;
      logic       p_bc0;
      logic       p_resync;
      logic       p_ovf;
      logic [1:0] p_bx;
      logic       p_ttc_en;
      logic       p_fctrl;
      logic [7:0] p_sep;
      fd = $fopen(PAT_FILE, "r");
      if (fd == 0) abort_run({"Cannot open pattern file ", PAT_FILE});
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line.getc(0) == "#") continue;   // Comment or blank
         n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h", p_gem, p_bc0, p_resync, p_ovf,
                            p_bx, p_ttc_en, p_fctrl, p_sep);
         if (n_fields != 8) abort_run({"Malformed pattern line: ", line});
         write_ctrl(1'b0, p_ttc_en, p_fctrl, 1'b0);
         gem_data     = p_gem;                                  // Held for the whole frame
         ttc.bc0      = p_bc0;
         ttc.resync   = p_resync;
         ttc.overflow = p_ovf;
         ttc.bx_lsbs  = p_bx;
         wait_frame_start();
         check_value($sformatf("separator, pattern %0d", n_lines),
                     64'(tx[0].word.raw[7:0]), 64'(p_sep));
         check_frame(p_gem, p_sep);
         n_lines++;
      end
      $fclose(fd);
      if (n_lines == 0) abort_run("Pattern file holds no patterns");
   endtask

   // Sequence --------------------
   initial begin
      k_char_t seq_chars [4];
      seq_chars = '{8'hBC, 8'hF7, 8'hFB, 8'hFD};                // K.28.5 K.23.7 K.27.7 K.29.7
      gem_data  = '0;
      ttc       = '0;
      apb_req   = '0;
      ctrl_bits = 4'b0110;                                      // CTRL after reset

      // Not ready after reset, links idle
      wait_reset();
      for (int i = 0; i < 5; i++) begin
         @(negedge clock_40);
         check_value("ready_o", 64'(ready), 64'(0));
         check_value("tx_o[0]", 64'(tx[0]), 64'({16'hFFFC, 2'b01}));
         check_value("tx_o[1]", 64'(tx[1]), 64'({16'hFFFC, 2'b01}));
      end
      reg_check(ADDR_STATUS, 32'h0, 1'b0, "STATUS");

      // Ready, then forced off and back
      wait_ready(1'b1);
      reg_check(ADDR_STATUS, 32'h3, 1'b0, "STATUS");
      write_ctrl(1'b1, 1'b1, 1'b1, 1'b0);
      wait_idle();
      reg_check(ADDR_STATUS, 32'h2, 1'b0, "STATUS");            // Startup still done
      write_ctrl(1'b0, 1'b1, 1'b1, 1'b0);
      wait_ready(1'b1);

      // Local cycle restarts at BC after ready
      write_ctrl(1'b1, 1'b1, 1'b0, 1'b0);
      wait_idle();
      write_ctrl(1'b0, 1'b1, 1'b0, 1'b0);
      wait_ready(1'b1);
      for (int f = 0; f < 4; f++) begin
         wait_frame_start();
         check_value($sformatf("separator, local frame %0d", f),
                     64'(tx[0].word.raw[7:0]), 64'(seq_chars[f]));
      end

      run_patterns();

      // Unmapped addresses
      reg_check(ADDR_CTRL, 32'(ctrl_bits), 1'b0, "CTRL");
      reg_check(8'h08, 32'h0, 1'b1, "address 0x08");
      reg_write(8'h10, 32'hF, 1'b1);                            // Must not reach CTRL
      reg_check(ADDR_CTRL, 32'(ctrl_bits), 1'b0, "CTRL");

      // Restart drops startup and ready
      write_ctrl(ctrl_bits[3], ctrl_bits[2], ctrl_bits[1], 1'b1);
      reg_check(ADDR_STATUS, 32'h0, 1'b0, "STATUS");
      check_value("ready_o", 64'(ready), 64'(0));
      wait_ready(1'b1);
      reg_check(ADDR_STATUS, 32'h3, 1'b0, "STATUS");
      reg_check(ADDR_CTRL, 32'(ctrl_bits), 1'b0, "CTRL");

      $display("TEST PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// File: trig_link.f
hdl/trig_link_pkg.sv
hdl/apb_ctrl_regs.sv
hdl/link_startup.sv
hdl/sep_char_select.sv
hdl/link_framer.sv
hdl/trig_link_top.sv
sim/tb_clock_gen.sv
sim/tb_trig_link.sv

// File: Makefile
# Verilator simulation of the trigger-link framer
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module tb_trig_link \
		-f trig_link.f --Mdir obj_dir -o tb_trig_link
	@./obj_dir/tb_trig_link > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAILED" $(LOG) || [ $$status -ne 0 ]; then \
		echo "Simulation failed"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir $(LOG)

// File: sim/trig_link_patterns.txt
# gem_data(112 bits hex) bc0 resync overflow bx_lsbs ttc_chars_en frame_ctrl_ttc sep(hex)
# Link 0 takes gem_data bits 55:0, link 1 bits 111:56
00112233445566778899aabbccdd 1 0 0 0 1 1 1c
0123456789abcdef0123456789ab 0 1 0 1 1 1 3c
fedcba9876543210fedcba987654 0 0 1 2 1 1 fe
a5a5a5a5a5a5a55a5a5a5a5a5a5a 1 1 0 3 1 1 1c
13579bdf02468ace13579bdf0246 0 1 1 0 1 1 3c
# Bunch-counter cycle
deadbeefcafef00dfeedface1234 0 0 0 0 1 1 bc
0f1e2d3c4b5a69788796a5b4c3d2 0 0 0 1 1 1 f7
5555aaaa5555aaaa5555aaaa5555 0 0 0 2 1 1 fb
8000000000000180000000000001 0 0 0 3 1 1 fd
# TTC characters disabled, cycle still from the bunch counter
1111222233334444555566667777 1 0 0 0 0 1 bc
89abcdef0123456789abcdef0123 0 1 0 3 0 1 fd
7f7f7f7f7f7f7ff7f7f7f7f7f7f7 0 0 1 1 0 1 f7
3c3c3c3c3c3c3cc3c3c3c3c3c3c3 1 1 1 2 0 1 fb
# Local cycle selected, TTC characters still win
0000000000ffff0000000000ffff 1 0 0 2 1 0 1c
123456789abcdef123456789abcd 0 0 1 3 1 0 fe
# Data corner cases
0000000000000000000000000000 0 0 0 1 1 1 f7
ffffffffffffffffffffffffffff 0 0 0 3 1 1 fd
c0ffee00c0ffee00c0ffee00c0ff 0 0 1 2 1 1 fe
